// ==== dsiq_core.f ====
+incdir+include
design/dsiq_stream_pkg.sv
design/dsiq_status_pkg.sv
design/dsiq_packer.sv
design/dsiq_fifo.sv
design/dsiq_tx_reader.sv
design/dsiq_core.sv
test/dsiq_core_sva.sv
test/dsiq_core_tb.sv

// ==== Bender.yml ====
package:
  name: dsiq_core

sources:
  - include_dirs:
      - include
    files:
      - design/dsiq_stream_pkg.sv
      - design/dsiq_status_pkg.sv
      - design/dsiq_packer.sv
      - design/dsiq_fifo.sv
      - design/dsiq_tx_reader.sv
      - design/dsiq_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/dsiq_core_sva.sv
      - test/dsiq_core_tb.sv

// ==== test/dsiq_core_tb.sv ====
//////////////////////////////////////////////////////////////////////
// directed tests for the downstream I/Q core: packing order, partial
// word drop, underrun, overflow and a random stream against a model
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "dsiq_cfg.svh"

module dsiq_core_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_CYCLES = 4000;

  typedef struct packed {
    dsiq_stream_pkg::iq_sample_t sample;
    logic                        underrun;
  } expect_t;

  logic                          clk_ctrl;
  logic                          rst_i;
  dsiq_stream_pkg::eth_byte_t    eth_byte_i;
  logic                          eth_flag_i;
  logic                          eth_valid_i;
  logic                          eth_last_i;
  logic                          tx_en_i;
  logic                          tx_strobe_i;
  dsiq_stream_pkg::iq_sample_t   iq_o;
  logic                          iq_valid_o;
  logic                          underrun_o;
  dsiq_status_pkg::dsiq_status_t status_o;

  // reference model state
  dsiq_stream_pkg::iq_sample_t fifo_model[$];
  expect_t                     expect_q[$];
  expect_t                     want;
  logic [7:0]                  part_data[4];
  logic                        part_flag[4];
  int                          part_cnt;
  logic                        exp_overflow;
  int                          errors;
  int                          checks;
  int                          tests;
  int                          cycles;
  integer                      seed;

  dsiq_core uut (
    .clk_ctrl   (clk_ctrl),
    .rst_i      (rst_i),
    .eth_byte_i (eth_byte_i),
    .eth_flag_i (eth_flag_i),
    .eth_valid_i(eth_valid_i),
    .eth_last_i (eth_last_i),
    .tx_en_i    (tx_en_i),
    .tx_strobe_i(tx_strobe_i),
    .iq_o       (iq_o),
    .iq_valid_o (iq_valid_o),
    .underrun_o (underrun_o),
    .status_o   (status_o)
  );

  initial begin
    clk_ctrl = 1'b0;
    forever #2 clk_ctrl = ~clk_ctrl;
  end

  // run limit
  always @(posedge clk_ctrl) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Regression failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // output monitor, compares every valid sample in order
  ////////////////////////////////////////////////////////////////////

  always @(negedge clk_ctrl) begin
    if (!rst_i && iq_valid_o) begin
      if (expect_q.size() == 0) begin
        errors++;
        $display("sample at %0t arrived with no strobe pending", $time);
      end else begin
        want = expect_q.pop_front();
        checks++;
        if (iq_o !== want.sample || underrun_o !== want.underrun) begin
          errors++;
          $display("mismatch at %0t: got i=%h q=%h flags=%b underrun=%b", $time,
                   iq_o.i, iq_o.q, iq_o.flags, underrun_o);
          $display("  expected i=%h q=%h flags=%b underrun=%b",
                   want.sample.i, want.sample.q, want.sample.flags, want.underrun);
        end
      end
    end
  end

  // lane rule: lane0 byte is the high half of i, lane0 flag the top flag bit
  function automatic void store_word();
    dsiq_stream_pkg::iq_sample_t s;
    s.i     = {part_data[0], part_data[1]};
    s.q     = {part_data[2], part_data[3]};
    s.flags = {part_flag[0], part_flag[1], part_flag[2], part_flag[3]};
    if (fifo_model.size() == `DSIQ_DEPTH) exp_overflow = 1'b1;
    else fifo_model.push_back(s);
  endfunction

  function automatic void pack_byte(input logic [7:0] data, input logic flag,
                                    input logic last);
    part_data[part_cnt] = data;
    part_flag[part_cnt] = flag;
    part_cnt++;
    if (part_cnt == `DSIQ_LANES) begin
      store_word();
      part_cnt = 0;
    end else if (last) begin
      part_cnt = 0;
    end
  endfunction

  task automatic apply_reset();
    @(negedge clk_ctrl);
    rst_i       = 1'b1;
    eth_valid_i = 1'b0;
    eth_last_i  = 1'b0;
    tx_en_i     = 1'b1;
    tx_strobe_i = 1'b0;
    repeat (8) @(negedge clk_ctrl);
    rst_i = 1'b0;
    fifo_model.delete();
    expect_q.delete();
    part_cnt     = 0;
    exp_overflow = 1'b0;
  endtask

  task automatic send_byte(input logic [7:0] data, input logic flag, input logic last);
    @(negedge clk_ctrl);
    eth_byte_i  = data;
    eth_flag_i  = flag;
    eth_valid_i = 1'b1;
    eth_last_i  = last;
    pack_byte(data, flag, last);
  endtask

  task automatic end_packet();
    @(negedge clk_ctrl);
    eth_valid_i = 1'b0;
    eth_last_i  = 1'b0;
  endtask

  // one enabled strobe, the model decides sample or underrun
  task automatic strobe_once();
    expect_t e;
    @(negedge clk_ctrl);
    tx_en_i     = 1'b1;
    tx_strobe_i = 1'b1;
    if (fifo_model.size() > 0) begin
      e.sample   = fifo_model.pop_front();
      e.underrun = 1'b0;
    end else begin
      e.sample   = '0;
      e.underrun = 1'b1;
    end
    expect_q.push_back(e);
    @(negedge clk_ctrl);
    tx_strobe_i = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (expect_q.size() > 0 && n < 20) begin
      @(negedge clk_ctrl);
      n++;
    end
    if (expect_q.size() > 0) begin
      errors++;
      $display("%0d expected samples never appeared by %0t", expect_q.size(), $time);
      expect_q.delete();
    end
  endtask

  task automatic check_status(input int level, input logic overflow);
    repeat (2) @(negedge clk_ctrl);
    checks++;
    if (status_o.level !== dsiq_status_pkg::fifo_level_t'(level) ||
        status_o.overflow !== overflow) begin
      errors++;
      $display("mismatch at %0t: level=%0d overflow=%b, expected level=%0d overflow=%b",
               $time, status_o.level, status_o.overflow, level, overflow);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    $display("test %s done with %0d errors", name, errors - err_before);
  endtask

  ////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////

  task automatic packing_order();
    int e0;
    logic [7:0] pat;
    e0  = errors;
    pat = 8'b1001_0110;
    apply_reset();
    for (int k = 0; k < 8; k++) begin
      send_byte(8'(8'h11 * (k + 1)), pat[7-k], k == 7);
    end
    end_packet();
    strobe_once();
    strobe_once();
    wait_drain();
    check_status(fifo_model.size(), exp_overflow);
    report_test("packing_order", e0);
  endtask

  task automatic partial_drop();
    int e0;
    e0 = errors;
    apply_reset();
    for (int k = 0; k < 6; k++) begin
      send_byte(8'(8'ha0 + k), k[0], k == 5);
    end
    end_packet();
    // second strobe finds the FIFO empty
    strobe_once();
    strobe_once();
    wait_drain();
    check_status(0, 1'b0);
    report_test("partial_drop", e0);
  endtask

  task automatic underrun_empty();
    int e0;
    e0 = errors;
    apply_reset();
    strobe_once();
    wait_drain();
    check_status(0, 1'b0);
    report_test("underrun_empty", e0);
  endtask

  task automatic overflow_retention();
    int e0;
    e0 = errors;
    apply_reset();
    // strobes while disabled must not pop
    tx_en_i     = 1'b0;
    tx_strobe_i = 1'b1;
    // 20 words into a 16 word FIFO
    for (int k = 0; k < 80; k++) begin
      send_byte(8'(k) ^ 8'h5a, k[1], k == 79);
    end
    end_packet();
    tx_strobe_i = 1'b0;
    check_status(`DSIQ_DEPTH, 1'b1);
    repeat (`DSIQ_DEPTH) strobe_once();
    wait_drain();
    check_status(0, 1'b1);
    report_test("overflow_retention", e0);
  endtask

  task automatic random_stream();
    int e0;
    int nwords;
    e0 = errors;
    apply_reset();
    for (int p = 0; p < 40; p++) begin
      nwords = 1 + ($unsigned($random(seed)) % 3);
      for (int k = 0; k < 4 * nwords; k++) begin
        send_byte(8'($random(seed)), 1'($random(seed)), k == 4 * nwords - 1);
      end
      end_packet();
      for (int w = 0; w < nwords; w++) begin
        strobe_once();
        repeat ($unsigned($random(seed)) % 4) @(negedge clk_ctrl);
      end
    end
    wait_drain();
    check_status(0, 1'b0);
    report_test("random_stream", e0);
  endtask

  initial begin
    seed        = 6;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    cycles      = 0;
    rst_i       = 1'b1;
    eth_byte_i  = '0;
    eth_flag_i  = 1'b0;
    eth_valid_i = 1'b0;
    eth_last_i  = 1'b0;
    tx_en_i     = 1'b0;
    tx_strobe_i = 1'b0;
    packing_order();
    partial_drop();
    underrun_empty();
    overflow_retention();
    random_stream();
    // bound assertion failures
    errors += uut.u_fifo.u_fifo_sva.fails + uut.u_reader.u_reader_sva.fails;
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/dsiq_core_sva.sv ====
//////////////////////////////////////////////////////////////////////
// concurrent assertions on the lane word FIFO and the tx reader,
// bound into both modules
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "dsiq_cfg.svh"

module dsiq_core_sva (
  input wire                                clk_ctrl,
  input wire                                rst_i,
  input wire dsiq_status_pkg::dsiq_status_t status_i,
  input wire                                tx_en_i,
  input wire                                tx_strobe_i,
  input wire                                iq_valid_i,
  input wire                                underrun_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // failures seen, summed into the testbench error count
  int fails = 0;

  // fill level bounded by depth
  level_in_range: assert property (@(posedge clk_ctrl) disable iff (rst_i)
    status_i.level <= `DSIQ_DEPTH)
    else begin
      fails++;
      $error("fifo level above depth");
    end

  // overflow is sticky
  overflow_sticky: assert property (@(posedge clk_ctrl) disable iff (rst_i)
    $past(status_i.overflow) |-> status_i.overflow)
    else begin
      fails++;
      $error("overflow cleared without reset");
    end

  valid_after_strobe: assert property (@(posedge clk_ctrl) disable iff (rst_i)
    iq_valid_i |-> $past(tx_en_i && tx_strobe_i))
    else begin
      fails++;
      $error("sample valid without an enabled strobe");
    end

  underrun_with_valid: assert property (@(posedge clk_ctrl) disable iff (rst_i)
    underrun_i |-> iq_valid_i)
    else begin
      fails++;
      $error("underrun without sample valid");
    end

endmodule

bind dsiq_fifo dsiq_core_sva u_fifo_sva (
  .clk_ctrl   (clk_ctrl),
  .rst_i      (rst_i),
  .status_i   (status_o),
  .tx_en_i    (1'b0),
  .tx_strobe_i(1'b0),
  .iq_valid_i (1'b0),
  .underrun_i (1'b0)
);

bind dsiq_tx_reader dsiq_core_sva u_reader_sva (
  .clk_ctrl   (clk_ctrl),
  .rst_i      (rst_i),
  .status_i   ('0),
  .tx_en_i    (tx_en_i),
  .tx_strobe_i(tx_strobe_i),
  .iq_valid_i (iq_valid_o),
  .underrun_i (underrun_o)
);

`default_nettype wire

// ==== design/dsiq_core.sv ====
//////////////////////////////////////////////////////////////////////
// downstream transmit I/Q core: packer, lane word FIFO and reader
//////////////////////////////////////////////////////////////////////

`default_nettype none

module dsiq_core (
  input  wire                           clk_ctrl,
  input  wire                           rst_i,
  input  dsiq_stream_pkg::eth_byte_t    eth_byte_i,
  input  wire                           eth_flag_i,
  input  wire                           eth_valid_i,
  input  wire                           eth_last_i,
  input  wire                           tx_en_i,
  input  wire                           tx_strobe_i,
  output dsiq_stream_pkg::iq_sample_t   iq_o,
  output logic                          iq_valid_o,
  output logic                          underrun_o,
  output dsiq_status_pkg::dsiq_status_t status_o
);

  dsiq_stream_pkg::dsiq_word_t wr_word;
  logic                        wr_valid;
  dsiq_stream_pkg::dsiq_word_t rd_word;
  logic                        rd_valid;
  logic                        rd_ready;

  dsiq_packer u_packer (
    .clk_ctrl   (clk_ctrl),
    .rst_i      (rst_i),
    .eth_byte_i (eth_byte_i),
    .eth_flag_i (eth_flag_i),
    .eth_valid_i(eth_valid_i),
    .eth_last_i (eth_last_i),
    .wr_word_o  (wr_word),
    .wr_valid_o (wr_valid)
  );

  dsiq_fifo u_fifo (
    .clk_ctrl  (clk_ctrl),
    .rst_i     (rst_i),
    .wr_word_i (wr_word),
    .wr_valid_i(wr_valid),
    .rd_word_o (rd_word),
    .rd_valid_o(rd_valid),
    .rd_ready_i(rd_ready),
    .status_o  (status_o)
  );

  dsiq_tx_reader u_reader (
    .clk_ctrl   (clk_ctrl),
    .rst_i      (rst_i),
    .tx_en_i    (tx_en_i),
    .tx_strobe_i(tx_strobe_i),
    .rd_word_i  (rd_word),
    .rd_valid_i (rd_valid),
    .rd_ready_o (rd_ready),
    .iq_o       (iq_o),
    .iq_valid_o (iq_valid_o),
    .underrun_o (underrun_o)
  );

endmodule

`default_nettype wire

// ==== design/dsiq_tx_reader.sv ====
//////////////////////////////////////////////////////////////////////
// transmit reader: pops one lane word per enabled sample strobe and
// registers it as an I/Q sample with flags, or flags an underrun
//////////////////////////////////////////////////////////////////////

`default_nettype none

module dsiq_tx_reader (
  input  wire                         clk_ctrl,
  input  wire                         rst_i,
  input  wire                         tx_en_i,
  input  wire                         tx_strobe_i,
  input  dsiq_stream_pkg::dsiq_word_t rd_word_i,
  input  wire                         rd_valid_i,
  output logic                        rd_ready_o,
  output dsiq_stream_pkg::iq_sample_t iq_o,
  output logic                        iq_valid_o,
  output logic                        underrun_o
);

  logic                        take;
  dsiq_stream_pkg::iq_sample_t word_as_iq;
  dsiq_stream_pkg::iq_sample_t sample_q;

  assign take       = tx_en_i && tx_strobe_i;
  assign rd_ready_o = take;

  // lane0 and lane1 form I, lane2 and lane3 form Q
  assign word_as_iq.i     = {rd_word_i.lane0.data, rd_word_i.lane1.data};
  assign word_as_iq.q     = {rd_word_i.lane2.data, rd_word_i.lane3.data};
  assign word_as_iq.flags = {rd_word_i.lane0.flag, rd_word_i.lane1.flag,
                             rd_word_i.lane2.flag, rd_word_i.lane3.flag};

  // strobe handshake state
  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      iq_valid_o <= 1'b0;
      underrun_o <= 1'b0;
    end else begin
      iq_valid_o <= take;
      underrun_o <= take && !rd_valid_i;
    end
  end

  // sample payload, zero when nothing was queued
  always_ff @(posedge clk_ctrl) begin
    if (take) begin
      if (rd_valid_i) sample_q <= word_as_iq;
      else sample_q <= '0;
    end
  end

  assign iq_o = sample_q;

endmodule

`default_nettype wire

// ==== design/dsiq_fifo.sv ====
//////////////////////////////////////////////////////////////////////
// lane word FIFO: register-array circular buffer, first-word
// fall-through read side, fill level and sticky overflow
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "dsiq_cfg.svh"

module dsiq_fifo (
  input  wire                           clk_ctrl,
  input  wire                           rst_i,
  input  dsiq_stream_pkg::dsiq_word_t   wr_word_i,
  input  wire                           wr_valid_i,
  output dsiq_stream_pkg::dsiq_word_t   rd_word_o,
  output logic                          rd_valid_o,
  input  wire                           rd_ready_i,
  output dsiq_status_pkg::dsiq_status_t status_o
);

  localparam int unsigned PTR_W = $clog2(`DSIQ_DEPTH);
  localparam dsiq_status_pkg::fifo_level_t FULL_LEVEL = `DSIQ_LEVEL_W'(`DSIQ_DEPTH);

  dsiq_stream_pkg::dsiq_word_t  mem [`DSIQ_DEPTH];
  logic [PTR_W-1:0]             wr_ptr;
  logic [PTR_W-1:0]             rd_ptr;
  dsiq_status_pkg::fifo_level_t count;
  logic                         overflow_q;
  logic                         empty;
  logic                         full;
  logic                         do_rd;
  logic                         do_wr;

  assign empty = (count == '0);
  assign full  = (count == FULL_LEVEL);

  // a read frees a slot in the same cycle, so a full write may still land
  assign do_rd = rd_ready_i && !empty;
  assign do_wr = wr_valid_i && (!full || do_rd);

  ////////////////////////////////////////////////////////////////////
  // pointers, level, overflow
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // dropped word
      if (wr_valid_i && !do_wr) overflow_q <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_ctrl) begin
    if (do_wr) mem[wr_ptr] <= wr_word_i;
  end

  // head word is always on the output
  assign rd_word_o  = mem[rd_ptr];
  assign rd_valid_o = !empty;

  assign status_o = '{level: count, overflow: overflow_q};

endmodule

`default_nettype wire

// ==== design/dsiq_packer.sv ====
//////////////////////////////////////////////////////////////////////
// byte packer: gathers four flagged payload bytes into one lane
// word and writes it with a one-cycle valid
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "dsiq_cfg.svh"

module dsiq_packer (
  input  wire                        clk_ctrl,
  input  wire                        rst_i,
  input  dsiq_stream_pkg::eth_byte_t eth_byte_i,
  input  wire                        eth_flag_i,
  input  wire                        eth_valid_i,
  input  wire                        eth_last_i,
  output dsiq_stream_pkg::dsiq_word_t wr_word_o,
  output logic                       wr_valid_o
);

  localparam logic [1:0] LAST_LANE = 2'(`DSIQ_LANES - 1);

  logic [1:0]                  lane_cnt;
  dsiq_stream_pkg::dsiq_lane_t lane_in;
  dsiq_stream_pkg::dsiq_word_t word_q;

  assign lane_in = '{flag: eth_flag_i, data: eth_byte_i};

  // lane counter and word valid
  always_ff @(posedge clk_ctrl) begin
    if (rst_i) begin
      lane_cnt   <= '0;
      wr_valid_o <= 1'b0;
    end else begin
      wr_valid_o <= eth_valid_i && (lane_cnt == LAST_LANE);
      if (eth_valid_i) begin
        // a short tail at end of packet is simply dropped
        if (lane_cnt == LAST_LANE || eth_last_i) lane_cnt <= '0;
        else lane_cnt <= lane_cnt + 2'd1;
      end
    end
  end

  // steer byte into its lane
  always_ff @(posedge clk_ctrl) begin
    if (eth_valid_i) begin
      case (lane_cnt)
        2'd0:    word_q.lane0 <= lane_in;
        2'd1:    word_q.lane1 <= lane_in;
        2'd2:    word_q.lane2 <= lane_in;
        default: word_q.lane3 <= lane_in;
      endcase
    end
  end

  assign wr_word_o = word_q;

endmodule

`default_nettype wire

// ==== design/dsiq_status_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// buffer status types: fill level and the status struct
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "dsiq_cfg.svh"

package dsiq_status_pkg;

  // words currently stored
  typedef logic [`DSIQ_LEVEL_W-1:0] fifo_level_t;

  // overflow is sticky until reset
  typedef struct packed {
    fifo_level_t level;
    logic        overflow;
  } dsiq_status_t;

endpackage

`default_nettype wire

// ==== design/dsiq_stream_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// data stream types: payload byte, flagged lane, lane word and
// the transmit I/Q sample
//////////////////////////////////////////////////////////////////////

`default_nettype none

package dsiq_stream_pkg;

  // one ethernet payload byte
  typedef logic [7:0] eth_byte_t;

  // byte plus its per-byte flag, 9 bits
  typedef struct packed {
    logic      flag;
    eth_byte_t data;
  } dsiq_lane_t;

  // four lanes, lane0 is the first byte received
  typedef struct packed {
    dsiq_lane_t lane0;
    dsiq_lane_t lane1;
    dsiq_lane_t lane2;
    dsiq_lane_t lane3;
  } dsiq_word_t;

  // one I or Q component
  typedef logic [15:0] iq_comp_t;

  typedef struct packed {
    iq_comp_t   i;
    iq_comp_t   q;
    logic [3:0] flags;
  } iq_sample_t;

endpackage

`default_nettype wire

// ==== include/dsiq_cfg.svh ====
//////////////////////////////////////////////////////////////////////
// build-time sizes for the downstream I/Q path
// FIFO depth, fill level width and bytes per lane word
//////////////////////////////////////////////////////////////////////

`ifndef DSIQ_CFG_SVH
`define DSIQ_CFG_SVH

// words held by the FIFO, power of two
`define DSIQ_DEPTH 16

// wide enough for 0 .. DSIQ_DEPTH
`define DSIQ_LEVEL_W 5

// payload bytes gathered into one word
`define DSIQ_LANES 4

`endif
